// File: cmd_engine_top.f
source/cmd_engine_pkg.sv
source/fifo_v3.sv
source/apb_cmd_port.sv
source/cmd_exec_stage.sv
source/cmd_engine_top.sv
test/cmd_engine_tb.sv

// File: Bender.yml
package:
  name: cmd_engine

sources:
  # package first, then leaf modules, then the top level
  - files:
      - source/cmd_engine_pkg.sv
      - source/fifo_v3.sv
      - source/apb_cmd_port.sv
      - source/cmd_exec_stage.sv
      - source/cmd_engine_top.sv

  # testbench of cmd_engine_top
  - target: test
    files:
      - test/cmd_engine_tb.sv

// File: test/cmd_engine_tb.sv
// testbench of the command engine
// apb bus tasks, status polling, typed compare tasks
// table of operations with expected results, ordering, back-pressure, errors, flush
`timescale 1ns/100ps

module cmd_engine_tb
    import cmd_engine_pkg::*;
();

    localparam int CMD_DEPTH = 4;
    localparam int RES_DEPTH = 4;
    // commands the engine holds before a CMD write stalls
    localparam int FILL_CNT  = CMD_DEPTH + 1 + RES_DEPTH;
    localparam int NUM_VEC   = 16;
    localparam int NUM_FIXED = 7;
    // bound on every wait, in clock cycles
    localparam int TIMEOUT   = 200;
    // STATUS patterns
    localparam logic [31:0] ST_EMPTY = 32'h0000_0005;
    localparam logic [31:0] ST_FULL  = 32'h0000_000A;

    // one row of the operation table
    typedef struct packed {
        opcode_e          op;
        logic [11:0]      a;
        logic [11:0]      b;
        logic [7:0]       tag;
        result_t          exp;
    } vec_t;

    logic      clk_i;
    logic      rst_i;
    apb_req_t  req;
    apb_resp_t resp;

    vec_t      table_q [NUM_VEC];
    result_t   exp_q [$];
    int        err_count;
    int        tests_run;
    int        tests_failed;

    cmd_engine_top #(
        .CMD_DEPTH (CMD_DEPTH),
        .RES_DEPTH (RES_DEPTH)
    ) DUT (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .apb_req_i  (req),
        .apb_resp_o (resp)
    );

    // 8 ns clock
    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // expected value from the opcode rules, zero-extended operands
    function automatic result_t model_result(opcode_e op, logic [11:0] a, logic [11:0] b,
                                             logic [7:0] tag);
        result_t r;
        r.tag = tag;
        case (op)
            OP_ADD: r.value = 24'(a) + 24'(b);
            OP_SUB: r.value = 24'(a) - 24'(b);
            OP_MUL: r.value = 24'(a) * 24'(b);
            OP_XOR: r.value = {12'b0, a ^ b};
            OP_MAX: r.value = (a > b) ? 24'(a) : 24'(b);
            default: r.value = '0;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] operand_word(logic [11:0] a, logic [11:0] b);
        return {4'b0, b, 4'b0, a};
    endfunction

    function automatic logic [31:0] cmd_word(logic [2:0] op, logic [7:0] tag);
        return {16'b0, tag, 5'b0, op};
    endfunction

    // setup cycle, then access until pready, sampled at the falling edge
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int cycles;
        cycles = 0;
        @(posedge clk_i);
        #1;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = wr;
        req.paddr   = addr;
        req.pwdata  = wdata;
        @(posedge clk_i);
        #1;
        req.penable = 1'b1;
        @(negedge clk_i);
        while (!resp.pready && cycles < TIMEOUT) begin
            cycles++;
            @(negedge clk_i);
        end
        if (!resp.pready) begin
            $display("timeout at %0t: no pready for access to address %h", $time, addr);
            err_count++;
        end
        rdata = resp.prdata;
        err   = resp.pslverr;
        // transfer completes on this edge
        @(posedge clk_i);
        #1;
        req = '0;
    endtask

    // read STATUS until the masked bits match
    task automatic poll_status(input logic [31:0] mask, input logic [31:0] value);
        logic [31:0] st;
        logic        err;
        int          polls;
        polls = 0;
        apb_access(1'b0, ADDR_STATUS, '0, st, err);
        while (((st & mask) != value) && polls < TIMEOUT) begin
            polls++;
            apb_access(1'b0, ADDR_STATUS, '0, st, err);
        end
        if ((st & mask) != value) begin
            $display("timeout at %0t: STATUS never reached %h under mask %h", $time, value, mask);
            err_count++;
        end
    endtask

    task automatic check_result(input string name, input result_t exp, input result_t act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_status(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s pslverr expected %b got %b", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    // hold a CMD write in its access phase and expect pready low throughout
    // the bus is then released so the host can drain a result
    task automatic check_stall(input logic [31:0] wdata, input int hold_cycles);
        int low_cycles;
        low_cycles = 0;
        @(posedge clk_i);
        #1;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = 1'b1;
        req.paddr   = ADDR_CMD;
        req.pwdata  = wdata;
        @(posedge clk_i);
        #1;
        req.penable = 1'b1;
        repeat (hold_cycles) begin
            @(negedge clk_i);
            if (!resp.pready) begin
                low_cycles++;
            end
        end
        @(posedge clk_i);
        #1;
        req = '0;
        if (low_cycles != hold_cycles) begin
            $display("error at %0t: CMD write completed while command queue was full", $time);
            err_count++;
        end
    endtask

    // fixed edge values first, random rows after
    task automatic build_table();
        table_q[0] = '{OP_MUL, 12'hFFF, 12'hFFF, 8'h01, '{8'h01, 24'hFFE001}};
        table_q[1] = '{OP_SUB, 12'h000, 12'h001, 8'h02, '{8'h02, 24'hFFFFFF}};
        table_q[2] = '{OP_ADD, 12'hFFF, 12'hFFF, 8'h03, '{8'h03, 24'h001FFE}};
        table_q[3] = '{OP_XOR, 12'hA5A, 12'h5A5, 8'h04, '{8'h04, 24'h000FFF}};
        table_q[4] = '{OP_MAX, 12'h800, 12'h7FF, 8'h05, '{8'h05, 24'h000800}};
        table_q[5] = '{OP_MAX, 12'h000, 12'hFFF, 8'h06, '{8'h06, 24'h000FFF}};
        table_q[6] = '{OP_SUB, 12'hFFF, 12'h000, 8'hFF, '{8'hFF, 24'h000FFF}};
        for (int i = NUM_FIXED; i < NUM_VEC; i++) begin
            table_q[i].op  = opcode_e'($urandom_range(4, 0));
            table_q[i].a   = 12'($urandom);
            table_q[i].b   = 12'($urandom);
            table_q[i].tag = 8'(8'h10 + i);
            table_q[i].exp = model_result(table_q[i].op, table_q[i].a, table_q[i].b,
                                          table_q[i].tag);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic [31:0] st_before;
        logic        err;
        int          start_errs;
        int          seed_val;
        opcode_e     op;
        logic [11:0] a;
        logic [11:0] b;

        rst_i        = 1'b1;
        req          = '0;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed_val     = $urandom(20);
        build_table();
        repeat (3) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        // one command at a time through the whole pipeline
        start_errs = err_count;
        for (int i = 0; i < NUM_VEC; i++) begin
            apb_access(1'b1, ADDR_OPERANDS, operand_word(table_q[i].a, table_q[i].b), rdata, err);
            apb_access(1'b1, ADDR_CMD, cmd_word(table_q[i].op, table_q[i].tag), rdata, err);
            check_err("CMD", 1'b0, err);
            poll_status(32'h4, 32'h0);
            apb_access(1'b0, ADDR_RESULT, '0, rdata, err);
            check_err("RESULT", 1'b0, err);
            check_result("RESULT", table_q[i].exp, result_t'(rdata));
        end
        report_test("table_loop", start_errs);

        // fill queues and holding register without reading
        start_errs = err_count;
        for (int i = 0; i < FILL_CNT; i++) begin
            op = opcode_e'(i % 5);
            a  = 12'(i * 12'h111);
            b  = 12'(12'hFFF - i * 7);
            apb_access(1'b1, ADDR_OPERANDS, operand_word(a, b), rdata, err);
            apb_access(1'b1, ADDR_CMD, cmd_word(op, 8'(8'h80 + i)), rdata, err);
            check_err("CMD", 1'b0, err);
            exp_q.push_back(model_result(op, a, b, 8'(8'h80 + i)));
        end
        poll_status(ST_FULL, ST_FULL);
        apb_access(1'b0, ADDR_STATUS, '0, rdata, err);
        check_status("STATUS", ST_FULL, rdata);
        report_test("backpressure_fill", start_errs);

        // one command beyond capacity waits on pready
        start_errs = err_count;
        apb_access(1'b1, ADDR_OPERANDS, operand_word(12'h123, 12'h456), rdata, err);
        check_stall(cmd_word(OP_MUL, 8'hC0), 6);
        apb_access(1'b0, ADDR_RESULT, '0, rdata, err);
        check_err("RESULT", 1'b0, err);
        check_result("RESULT", exp_q.pop_front(), result_t'(rdata));
        // room freed, the write now goes through
        apb_access(1'b1, ADDR_CMD, cmd_word(OP_MUL, 8'hC0), rdata, err);
        check_err("CMD", 1'b0, err);
        exp_q.push_back(model_result(OP_MUL, 12'h123, 12'h456, 8'hC0));
        report_test("wait_state", start_errs);

        // drain in issue order, the extra command last
        start_errs = err_count;
        while (exp_q.size() > 0) begin
            poll_status(32'h4, 32'h0);
            apb_access(1'b0, ADDR_RESULT, '0, rdata, err);
            check_err("RESULT", 1'b0, err);
            check_result("RESULT", exp_q.pop_front(), result_t'(rdata));
        end
        apb_access(1'b0, ADDR_STATUS, '0, rdata, err);
        check_status("STATUS", ST_EMPTY, rdata);
        report_test("ordering", start_errs);

        // error responses
        start_errs = err_count;
        apb_access(1'b0, ADDR_STATUS, '0, st_before, err);
        apb_access(1'b1, ADDR_CMD, cmd_word(3'd5, 8'h55), rdata, err);
        check_err("CMD opcode 5", 1'b1, err);
        apb_access(1'b0, ADDR_STATUS, '0, rdata, err);
        check_status("STATUS", st_before, rdata);
        apb_access(1'b0, ADDR_RESULT, '0, rdata, err);
        check_err("RESULT empty", 1'b1, err);
        check_status("prdata", 32'h0, rdata);
        apb_access(1'b0, 8'h14, '0, rdata, err);
        check_err("address 0x14", 1'b1, err);
        apb_access(1'b1, ADDR_STATUS, 32'hFFFF_FFFF, rdata, err);
        check_err("STATUS write", 1'b1, err);
        report_test("error_responses", start_errs);

        // flush clears queues and stage
        start_errs = err_count;
        apb_access(1'b1, ADDR_OPERANDS, operand_word(12'h00A, 12'h00B), rdata, err);
        for (int i = 0; i < 2; i++) begin
            apb_access(1'b1, ADDR_CMD, cmd_word(OP_ADD, 8'(8'hE0 + i)), rdata, err);
        end
        // two results parked in the result queue, command queue empty
        poll_status(32'h000F_0000, 32'h0002_0000);
        apb_access(1'b0, ADDR_STATUS, '0, rdata, err);
        check_status("STATUS", 32'h0002_0001, rdata);
        for (int i = 2; i < 6; i++) begin
            apb_access(1'b1, ADDR_CMD, cmd_word(OP_ADD, 8'(8'hE0 + i)), rdata, err);
        end
        // result queue full, one result held, one command waiting
        poll_status(32'h0000_0F08, 32'h0000_0108);
        apb_access(1'b0, ADDR_STATUS, '0, rdata, err);
        check_status("STATUS", 32'h0000_0108, rdata);
        apb_access(1'b1, ADDR_CTRL, 32'h1, rdata, err);
        check_err("CTRL", 1'b0, err);
        apb_access(1'b0, ADDR_STATUS, '0, rdata, err);
        check_status("STATUS", ST_EMPTY, rdata);
        apb_access(1'b0, ADDR_RESULT, '0, rdata, err);
        check_err("RESULT after flush", 1'b1, err);
        report_test("flush", start_errs);

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: source/cmd_engine_top.sv
// top level of the command engine
// apb port, command queue, execute stage and result queue
`timescale 1ns/100ps

module cmd_engine_top
    import cmd_engine_pkg::*;
#(
    parameter int unsigned CMD_DEPTH = 4,
    parameter int unsigned RES_DEPTH = 4
) (
    input  logic      clk_i,
    input  logic      rst_i,
    input  apb_req_t  apb_req_i,
    output apb_resp_t apb_resp_o
);

    // usage widths of the two queues
    localparam int unsigned CMD_AW = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int unsigned RES_AW = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;

    // command path
    logic              cmd_push;
    cmd_t              cmd_in;
    logic              cmd_full;
    logic              cmd_empty;
    cmd_t              cmd_head;
    logic              cmd_pop;
    logic [CMD_AW-1:0] cmd_usage_raw;
    logic [3:0]        cmd_usage;

    // result path
    logic              res_push;
    result_t           res_in;
    logic              res_full;
    logic              res_empty;
    result_t           res_head;
    logic              res_pop;
    logic [RES_AW-1:0] res_usage_raw;
    logic [3:0]        res_usage;

    logic              flush;

    // usage fields in STATUS are 4 bits wide
    assign cmd_usage = 4'(cmd_usage_raw);
    assign res_usage = 4'(res_usage_raw);

    apb_cmd_port u_apb_port (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .apb_req_i   (apb_req_i),
        .cmd_full_i  (cmd_full),
        .cmd_empty_i (cmd_empty),
        .res_full_i  (res_full),
        .res_empty_i (res_empty),
        .cmd_usage_i (cmd_usage),
        .res_usage_i (res_usage),
        .res_data_i  (res_head),
        .apb_resp_o  (apb_resp_o),
        .cmd_push_o  (cmd_push),
        .cmd_data_o  (cmd_in),
        .res_pop_o   (res_pop),
        .flush_o     (flush)
    );

    fifo_v3 #(
        .FALL_THROUGH (1'b0),
        .DEPTH        (CMD_DEPTH),
        .dtype        (cmd_t)
    ) u_cmd_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .flush_i (flush),
        .push_i  (cmd_push),
        .data_i  (cmd_in),
        .full_o  (cmd_full),
        .empty_o (cmd_empty),
        .usage_o (cmd_usage_raw),
        .data_o  (cmd_head),
        .pop_i   (cmd_pop)
    );

    cmd_exec_stage u_exec_stage (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (flush),
        .cmd_data_i  (cmd_head),
        .cmd_empty_i (cmd_empty),
        .cmd_pop_o   (cmd_pop),
        .res_data_o  (res_in),
        .res_push_o  (res_push),
        .res_full_i  (res_full)
    );

    fifo_v3 #(
        .FALL_THROUGH (1'b0),
        .DEPTH        (RES_DEPTH),
        .dtype        (result_t)
    ) u_res_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .flush_i (flush),
        .push_i  (res_push),
        .data_i  (res_in),
        .full_o  (res_full),
        .empty_o (res_empty),
        .usage_o (res_usage_raw),
        .data_o  (res_head),
        .pop_i   (res_pop)
    );

endmodule

// File: source/cmd_exec_stage.sv
// execute stage between the command and result queues
// opcode decode and arithmetic at result width
// one holding register with valid flag and back-pressure
`timescale 1ns/100ps

module cmd_exec_stage
    import cmd_engine_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    flush_i,
    input  cmd_t    cmd_data_i,
    input  logic    cmd_empty_i,
    output logic    cmd_pop_o,
    output result_t res_data_o,
    output logic    res_push_o,
    input  logic    res_full_i
);

    logic [RESULT_W-1:0] a_ext;
    logic [RESULT_W-1:0] b_ext;
    logic [RESULT_W-1:0] value;
    logic                hold_valid_q;
    result_t             hold_q;

    // holding register drains whenever the result queue has room
    assign res_push_o = hold_valid_q && !res_full_i;

    // take the next command if the holding register is free
    // or empties on this same edge
    // no pop during flush so that nothing survives it
    assign cmd_pop_o = !flush_i && !cmd_empty_i && (!hold_valid_q || res_push_o);

    assign res_data_o = hold_q;

    // operands zero-extended to the result width
    assign a_ext = RESULT_W'(cmd_data_i.a);
    assign b_ext = RESULT_W'(cmd_data_i.b);

    always_comb begin
        case (cmd_data_i.opcode)
            OP_ADD: value = a_ext + b_ext;
            // wraps modulo 2**24
            OP_SUB: value = a_ext - b_ext;
            // 12 x 12 bits fits in 24 without loss
            OP_MUL: value = a_ext * b_ext;
            OP_XOR: value = a_ext ^ b_ext;
            // unsigned compare
            OP_MAX: value = (a_ext > b_ext) ? a_ext : b_ext;
            default: value = '0;
        endcase
    end

    // valid flag of the holding register
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            hold_valid_q <= 1'b0;
        end else if (flush_i) begin
            hold_valid_q <= 1'b0;
        end else if (cmd_pop_o) begin
            hold_valid_q <= 1'b1;
        end else if (res_push_o) begin
            hold_valid_q <= 1'b0;
        end
    end

    // result and tag captured one cycle after the pop
    always_ff @(posedge clk_i) begin
        if (cmd_pop_o) begin
            hold_q.tag   <= cmd_data_i.tag;
            hold_q.value <= value;
        end
    end

    // a stalled result stays put until the queue takes it
    stall_holds_result: assert property (@(posedge clk_i) disable iff (rst_i)
        hold_valid_q && res_full_i && !flush_i |=> hold_valid_q && $stable(hold_q))
        else $error("held result lost during stall");

endmodule

// File: source/apb_cmd_port.sv
// apb slave of the command engine
// operand register, register map decode, opcode check
// wait states on a full command queue, push/pop/flush strobes
`timescale 1ns/100ps

module apb_cmd_port
    import cmd_engine_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  apb_req_t  apb_req_i,
    input  logic      cmd_full_i,
    input  logic      cmd_empty_i,
    input  logic      res_full_i,
    input  logic      res_empty_i,
    input  logic [3:0] cmd_usage_i,
    input  logic [3:0] res_usage_i,
    input  result_t   res_data_i,
    output apb_resp_t apb_resp_o,
    output logic      cmd_push_o,
    output cmd_t      cmd_data_o,
    output logic      res_pop_o,
    output logic      flush_o
);

    logic                 access;
    logic                 op_valid;
    logic                 opnd_we;
    logic                 pready;
    logic                 err;
    logic [31:0]          rdata;
    logic [31:0]          status_word;
    opcode_e              wr_opcode;
    logic [OPERAND_W-1:0] opa_q;
    logic [OPERAND_W-1:0] opb_q;

    // access phase of a transfer
    assign access    = apb_req_i.psel && apb_req_i.penable;
    assign wr_opcode = opcode_e'(apb_req_i.pwdata[2:0]);

    // only the five defined codes are accepted
    always_comb begin
        case (wr_opcode)
            OP_ADD, OP_SUB, OP_MUL, OP_XOR, OP_MAX: op_valid = 1'b1;
            default: op_valid = 1'b0;
        endcase
    end

    // command word from the CMD write and the stored operands
    always_comb begin
        cmd_data_o.opcode = wr_opcode;
        cmd_data_o.tag    = apb_req_i.pwdata[15:8];
        cmd_data_o.a      = opa_q;
        cmd_data_o.b      = opb_q;
    end

    // queue flags in the low nibble, usage counts above
    assign status_word = {12'b0, res_usage_i, 4'b0, cmd_usage_i,
                          4'b0, res_full_i, res_empty_i, cmd_full_i, cmd_empty_i};

    always_comb begin
        pready     = 1'b0;
        err        = 1'b0;
        rdata      = '0;
        opnd_we    = 1'b0;
        cmd_push_o = 1'b0;
        res_pop_o  = 1'b0;
        flush_o    = 1'b0;
        if (access) begin
            // zero wait states unless a push has to wait for room
            pready = 1'b1;
            case (apb_req_i.paddr)
                ADDR_OPERANDS: begin
                    if (apb_req_i.pwrite) begin
                        opnd_we = 1'b1;
                    end else begin
                        rdata = {4'b0, opb_q, 4'b0, opa_q};
                    end
                end
                ADDR_CMD: begin
                    if (!apb_req_i.pwrite || !op_valid) begin
                        err = 1'b1;
                    end else if (cmd_full_i) begin
                        // hold the host until the queue drains
                        pready = 1'b0;
                    end else begin
                        cmd_push_o = 1'b1;
                    end
                end
                ADDR_RESULT: begin
                    // empty read returns 0 and leaves the queue alone
                    if (apb_req_i.pwrite || res_empty_i) begin
                        err = 1'b1;
                    end else begin
                        rdata     = res_data_i;
                        res_pop_o = 1'b1;
                    end
                end
                ADDR_STATUS: begin
                    if (apb_req_i.pwrite) begin
                        err = 1'b1;
                    end else begin
                        rdata = status_word;
                    end
                end
                ADDR_CTRL: begin
                    if (!apb_req_i.pwrite) begin
                        err = 1'b1;
                    end else begin
                        flush_o = apb_req_i.pwdata[0];
                    end
                end
                default: err = 1'b1;
            endcase
        end
    end

    assign apb_resp_o.prdata  = rdata;
    assign apb_resp_o.pready  = pready;
    assign apb_resp_o.pslverr = pready && err;

    // b in bits 27:16, a in bits 11:0
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            opa_q <= '0;
            opb_q <= '0;
        end else if (opnd_we) begin
            opa_q <= apb_req_i.pwdata[OPERAND_W-1:0];
            opb_q <= apb_req_i.pwdata[16 +: OPERAND_W];
        end
    end

    // a completing transfer is in its access phase and came from a setup cycle
    pready_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
        apb_resp_o.pready |-> access && $past(apb_req_i.psel))
        else $error("pready outside of an access cycle");

endmodule

// File: source/fifo_v3.sv
// first-in first-out queue on a circular buffer
// flush, full/empty flags and usage count
// optional fall-through of the head when empty
// checks against push while full and pop while empty
`timescale 1ns/100ps

module fifo_v3 #(
    // head bypasses storage when the queue is empty
    parameter bit          FALL_THROUGH = 1'b0,
    // number of entries, at least 1
    parameter int unsigned DEPTH        = 8,
    parameter type         dtype        = logic [31:0],
    // pointer width, follows from DEPTH
    localparam int unsigned ADDR_DEPTH  = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  flush_i,
    input  logic                  push_i,
    input  dtype                  data_i,
    output logic                  full_o,
    output logic                  empty_o,
    output logic [ADDR_DEPTH-1:0] usage_o,
    output dtype                  data_o,
    input  logic                  pop_i
);

    // last valid pointer value before wrapping
    localparam logic [ADDR_DEPTH-1:0] LAST_PTR = ADDR_DEPTH'(DEPTH - 1);

    logic [ADDR_DEPTH-1:0] rd_ptr_q;
    logic [ADDR_DEPTH-1:0] rd_ptr_n;
    logic [ADDR_DEPTH-1:0] wr_ptr_q;
    logic [ADDR_DEPTH-1:0] wr_ptr_n;
    // one bit wider than the pointers so that full is representable
    logic [ADDR_DEPTH:0]   cnt_q;
    logic [ADDR_DEPTH:0]   cnt_n;
    logic                  do_push;
    logic                  do_pop;
    // storage
    dtype                  mem_q [DEPTH];

    // usage wraps to 0 at full, the full flag tells the two apart
    assign usage_o = cnt_q[ADDR_DEPTH-1:0];
    assign full_o  = (cnt_q == (ADDR_DEPTH + 1)'(DEPTH));
    // in fall-through mode a push into an empty queue is visible at once
    assign empty_o = (cnt_q == '0) && !(FALL_THROUGH && push_i);

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_comb begin
        rd_ptr_n = rd_ptr_q;
        wr_ptr_n = wr_ptr_q;
        cnt_n    = cnt_q;
        data_o   = mem_q[rd_ptr_q];

        // advance write side
        if (do_push) begin
            if (wr_ptr_q == LAST_PTR) begin
                wr_ptr_n = '0;
            end else begin
                wr_ptr_n = wr_ptr_q + 1'b1;
            end
            cnt_n = cnt_q + 1'b1;
        end

        // advance read side
        if (do_pop) begin
            if (rd_ptr_q == LAST_PTR) begin
                rd_ptr_n = '0;
            end else begin
                rd_ptr_n = rd_ptr_q + 1'b1;
            end
            cnt_n = cnt_q - 1'b1;
        end

        // push and pop together leave the count alone
        if (do_push && do_pop) begin
            cnt_n = cnt_q;
        end

        // bypass: the pushed word leaves straight away
        if (FALL_THROUGH && (cnt_q == '0) && push_i) begin
            data_o = data_i;
            if (pop_i) begin
                cnt_n    = cnt_q;
                rd_ptr_n = rd_ptr_q;
                wr_ptr_n = wr_ptr_q;
            end
        end
    end

    // pointers and count
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_n;
            wr_ptr_q <= wr_ptr_n;
            cnt_q    <= cnt_n;
        end
    end

    // entry written only on an accepted push
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // the producer must respect full
    full_write: assert property (@(posedge clk_i) disable iff (rst_i)
        full_o |-> !push_i)
        else $error("push into full queue");

    // the consumer must respect empty
    empty_read: assert property (@(posedge clk_i) disable iff (rst_i)
        empty_o |-> !pop_i)
        else $error("pop from empty queue");

endmodule

// File: source/cmd_engine_pkg.sv
// shared definitions of the command engine
// datapath widths, opcodes, command and result words
// apb request and response structs, register map
package cmd_engine_pkg;

    // datapath widths
    localparam int unsigned OPERAND_W = 12;
    localparam int unsigned RESULT_W  = 24;
    localparam int unsigned TAG_W     = 8;

    // operations of the execute stage
    // codes 5 to 7 are not defined
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_MUL = 3'd2,
        OP_XOR = 3'd3,
        OP_MAX = 3'd4
    } opcode_e;

    // one queued command, 35 bits
    typedef struct packed {
        opcode_e              opcode;
        logic [TAG_W-1:0]     tag;
        logic [OPERAND_W-1:0] a;
        logic [OPERAND_W-1:0] b;
    } cmd_t;

    // tagged result, laid out like the RESULT read word
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [RESULT_W-1:0] value;
    } result_t;

    // host to slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // slave to host
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_resp_t;

    // register map
    localparam logic [7:0] ADDR_OPERANDS = 8'h00;
    localparam logic [7:0] ADDR_CMD      = 8'h04;
    localparam logic [7:0] ADDR_RESULT   = 8'h08;
    localparam logic [7:0] ADDR_STATUS   = 8'h0C;
    localparam logic [7:0] ADDR_CTRL     = 8'h10;

endpackage
